// File: Makefile
VERILATOR  ?= verilator
TOP        := emu_ram_tb
FILELIST   := emu_ram.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)
SIM_ARGS   := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/emu_ram_checker.sv
`timescale 1ns/1ps

`include "emu_ram_consts.svh"

module emu_ram_checker import emu_ram_pkg::*; (
    input  logic      clk,
    input  logic      breq_valid,
    input  addr_req_t aw,
    input  logic      aw_valid,
    input  logic      aw_ready,
    input  w_beat_t   w,
    input  logic      w_valid,
    input  logic      w_ready,
    input  id_t       b_id,
    input  logic      b_valid,
    input  logic      b_ready,
    input  addr_req_t ar,
    input  logic      ar_valid,
    input  logic      ar_ready,
    input  r_beat_t   r,
    input  logic      r_valid,
    input  logic      r_ready,
    output int        errors
);

    data_t      ref_mem [2**`EMU_MEM_WORDS_LOG2];
    int         err_count = 0;
    word_addr_t wr_word;
    id_t        wr_id;
    logic       b_due = 1'b0;
    logic       b_wait = 1'b0;
    int         b_edges;
    word_addr_t rd_word;
    id_t        rd_id;
    len_t       rd_len;
    len_t       rd_beat;
    logic       rd_open = 1'b0;
    logic       r_wait = 1'b0;
    int         r_edges;

    assign errors = err_count;

    // Old word with the strobed bytes replaced
    function automatic data_t merge_bytes(input data_t old, input data_t data, input strb_t strb);
        data_t mask;
        for (int i = 0; i < `EMU_STRB_W; i++) begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        return (old & ~mask) | (data & mask);
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        err_count++;
    endtask

    // **************************************************
    // Edge-by-edge comparison
    // **************************************************
    always @(posedge clk) begin
        if (breq_valid) begin
            b_due   = 1'b0;
            b_wait  = 1'b0;
            rd_open = 1'b0;
            r_wait  = 1'b0;
        end else begin
            // Delays counted in edges since the closing handshake
            if (b_wait) begin
                b_edges++;
                if (b_valid) begin
                    b_wait = 1'b0;
                    if (b_edges - 1 != `EMU_W_DELAY) begin
                        report_error($sformatf("write response rose %0d edges after last beat",
                                               b_edges - 1));
                    end
                end
            end
            if (r_wait) begin
                r_edges++;
                if (r_valid) begin
                    r_wait = 1'b0;
                    if (r_edges - 1 != `EMU_R_DELAY + 1) begin
                        report_error($sformatf("first read beat rose %0d edges after address",
                                               r_edges - 1));
                    end
                end
            end

            if (aw_valid && aw_ready) begin
                wr_word = word_addr_t'(aw.addr >> `EMU_WORD_LSB);
                wr_id   = aw.id;
            end
            if (w_valid && w_ready) begin
                ref_mem[wr_word] = merge_bytes(ref_mem[wr_word], w.data, w.strb);
                wr_word++;
                if (w.last) begin
                    b_due   = 1'b1;
                    b_wait  = 1'b1;
                    b_edges = 0;
                end
            end
            if (b_valid && b_ready) begin
                if (!b_due) begin
                    report_error("write response without a pending write burst");
                end else if (b_id !== wr_id) begin
                    report_mismatch("b_id", 64'(b_id), 64'(wr_id));
                end
                b_due = 1'b0;
            end

            if (ar_valid && ar_ready) begin
                if (rd_open) begin
                    report_error("read address accepted while a burst was still open");
                end
                rd_open = 1'b1;
                rd_word = word_addr_t'(ar.addr >> `EMU_WORD_LSB);
                rd_id   = ar.id;
                rd_len  = ar.len;
                rd_beat = '0;
                r_wait  = 1'b1;
                r_edges = 0;
            end
            if (r_valid && r_ready) begin
                if (!rd_open) begin
                    report_error("read beat with no read burst open");
                end else begin
                    if (r.data !== ref_mem[rd_word]) begin
                        report_mismatch("r.data", r.data, ref_mem[rd_word]);
                    end
                    if (r.id !== rd_id) begin
                        report_mismatch("r.id", 64'(r.id), 64'(rd_id));
                    end
                    if (r.last !== (rd_beat == rd_len)) begin
                        report_mismatch("r.last", 64'(r.last), 64'(rd_beat == rd_len));
                    end
                    rd_open = (rd_beat != rd_len);
                    rd_word++;
                    rd_beat++;
                end
            end
        end
    end

endmodule

// File: bench/emu_ram_props.sv
`timescale 1ns/1ps

module emu_ram_props import emu_ram_pkg::*; (
    input  logic    clk,
    input  logic    breq_valid,
    input  logic    aw_ready,
    input  logic    w_ready,
    input  logic    ar_ready,
    input  id_t     b_id,
    input  logic    b_valid,
    input  logic    b_ready,
    input  r_beat_t r,
    input  logic    r_valid,
    input  logic    r_ready
);

    int fails = 0;

    // Nothing offered or accepted while in reset
    a_reset_quiet: assert property (@(posedge clk)
        breq_valid |-> !b_valid && !r_valid && !aw_ready && !ar_ready && !w_ready)
        else begin
            fails++;
            $error("handshake output active during reset");
        end

    a_b_hold: assert property (@(posedge clk) disable iff (breq_valid)
        b_valid && !b_ready |=> b_valid && $stable(b_id))
        else begin
            fails++;
            $error("write response dropped or changed before it was taken");
        end

    a_r_hold: assert property (@(posedge clk) disable iff (breq_valid)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else begin
            fails++;
            $error("read beat dropped or changed under back-pressure");
        end

endmodule

bind emu_ram emu_ram_props u_props (.*);

// File: bench/emu_ram_tb.sv
`timescale 1ns/1ps

module emu_ram_tb import emu_ram_pkg::*; ();

    localparam int WAIT_LIMIT = 400;
    localparam int CH_AW = 0;
    localparam int CH_W = 1;
    localparam int CH_B = 2;
    localparam int CH_AR = 3;
    localparam int CH_RLAST = 4;

    logic      clk;
    logic      breq_valid;
    addr_req_t aw;
    addr_req_t ar;
    w_beat_t   w;
    r_beat_t   r;
    id_t       b_id;
    logic      aw_valid;
    logic      aw_ready;
    logic      w_valid;
    logic      w_ready;
    logic      b_valid;
    logic      b_ready;
    logic      ar_valid;
    logic      ar_ready;
    logic      r_valid;
    logic      r_ready;

    int        seed = 32'hf8c80b4d;
    int        bench_errors = 0;
    int        chk_errors;
    bit        aborted = 1'b0;

    emu_ram u_dut (.*);

    emu_ram_checker u_check (.*, .errors(chk_errors));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Random back-pressure on B and R
    initial begin
        b_ready = 1'b0;
        r_ready = 1'b0;
        forever begin
            @(posedge clk);
            b_ready <= ($random(seed) & 3) != 0;
            r_ready <= ($random(seed) & 3) != 0;
        end
    end

    function automatic bit fired(input int chan);
        case (chan)
            CH_AW:   return aw_valid && aw_ready;
            CH_W:    return w_valid && w_ready;
            CH_B:    return b_valid && b_ready;
            CH_AR:   return ar_valid && ar_ready;
            default: return r_valid && r_ready && r.last;
        endcase
    endfunction

    function automatic data_t fill_word(input word_addr_t word);
        return {32'(word) * 32'h0100_0193, ~(32'(word) ^ 32'h5a5a_0000)};
    endfunction

    task automatic wait_fire(input int chan, input string what);
        int cycles;
        cycles = 0;
        if (aborted) begin
            return;
        end
        do begin
            @(posedge clk);
            cycles++;
        end while (!fired(chan) && cycles < WAIT_LIMIT);
        if (!fired(chan)) begin
            $display("ERROR at %0t: no %s within %0d cycles", $time, what, WAIT_LIMIT);
            bench_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            bench_errors++;
        end
    endtask

    // Start word and length inside the filled 64-word region
    task automatic pick_burst(output word_addr_t word, output int beats);
        beats = ($random(seed) & 15) + 1;
        word  = word_addr_t'(($random(seed) & 32'h7fff_ffff) % (65 - beats));
    endtask

    // **************************************************
    // Bursts
    // **************************************************
    task automatic write_burst(input id_t id, input word_addr_t word, input int beats,
                               input bit fill, input bit partial);
        w_beat_t beat;
        aw       <= '{id: id, addr: addr_t'(word) << 3, len: len_t'(beats - 1)};
        aw_valid <= 1'b1;
        wait_fire(CH_AW, "write address handshake");
        aw_valid <= 1'b0;
        for (int i = 0; i < beats; i++) begin
            beat.data = fill ? fill_word(word + word_addr_t'(i)) : {$random(seed), $random(seed)};
            beat.strb = partial ? strb_t'($random(seed)) : '1;
            beat.last = (i == beats - 1);
            w       <= beat;
            w_valid <= 1'b1;
            wait_fire(CH_W, "write data handshake");
        end
        w_valid <= 1'b0;
        wait_fire(CH_B, "write response");
    endtask

    task automatic offer_read(input id_t id, input word_addr_t word, input int beats);
        ar       <= '{id: id, addr: addr_t'(word) << 3, len: len_t'(beats - 1)};
        ar_valid <= 1'b1;
    endtask

    task automatic read_burst(input id_t id, input word_addr_t word, input int beats);
        offer_read(id, word, beats);
        wait_fire(CH_AR, "read address handshake");
        ar_valid <= 1'b0;
        wait_fire(CH_RLAST, "last read beat");
    endtask

    initial begin
        word_addr_t word;
        int         beats;
        id_t        id;

        breq_valid = 1'b1;
        aw         = '0;
        aw_valid   = 1'b0;
        w          = '0;
        w_valid    = 1'b0;
        ar         = '0;
        ar_valid   = 1'b0;
        repeat (2) @(posedge clk);
        breq_valid <= 1'b0;
        repeat (2) @(posedge clk);
        expect_bit("b_valid", b_valid, 1'b0);
        expect_bit("r_valid", r_valid, 1'b0);
        expect_bit("aw_ready", aw_ready, 1'b1);
        expect_bit("ar_ready", ar_ready, 1'b1);

        // Known contents over words 0 to 63
        for (int i = 0; i < 4; i++) begin
            write_burst(id_t'(i), word_addr_t'(i * 16), 16, 1'b1, 1'b0);
        end

        pick_burst(word, beats);
        id = id_t'($random(seed));
        write_burst(id, word, 1, 1'b0, 1'b0);
        read_burst(~id, word, 1);

        for (int n = 0; n < 40; n++) begin
            pick_burst(word, beats);
            id = id_t'($random(seed));
            write_burst(id, word, beats, 1'b0, 1'b1);
            offer_read(~id, word, beats);
            wait_fire(CH_AR, "read address handshake");
            // Next address waits in front of the busy read path
            pick_burst(word, beats);
            offer_read(id, word, beats);
            wait_fire(CH_RLAST, "last read beat");
            wait_fire(CH_AR, "read address handshake");
            ar_valid <= 1'b0;
            wait_fire(CH_RLAST, "last read beat");
        end

        // One more edge so the checker sees the final beat
        @(posedge clk);
        $display("Error count: checker %0d, bench %0d, assertions %0d",
                 chk_errors, bench_errors, u_dut.u_props.fails);
        if (chk_errors + bench_errors + u_dut.u_props.fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: emu_ram.f
+incdir+logic
logic/emu_ram_pkg.sv
logic/emu_ram_store.sv
logic/emu_ram_write_path.sv
logic/emu_ram_read_path.sv
logic/emu_ram.sv
bench/emu_ram_props.sv
bench/emu_ram_checker.sv
bench/emu_ram_tb.sv

// File: logic/emu_ram.sv
`timescale 1ns/1ps

module emu_ram import emu_ram_pkg::*; (
    input  logic      clk,
    input  logic      breq_valid,

    // Write address and data
    input  addr_req_t aw,
    input  logic      aw_valid,
    output logic      aw_ready,
    input  w_beat_t   w,
    input  logic      w_valid,
    output logic      w_ready,

    // Write response
    output id_t       b_id,
    output logic      b_valid,
    input  logic      b_ready,

    // Read address and data
    input  addr_req_t ar,
    input  logic      ar_valid,
    output logic      ar_ready,
    output r_beat_t   r,
    output logic      r_valid,
    input  logic      r_ready
);

    mem_wr_t mem_wr;
    mem_rd_t mem_rd;
    data_t   rd_data;

    emu_ram_write_path u_write_path (
        .clk        (clk),
        .breq_valid (breq_valid),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .b_id       (b_id),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .mem_wr     (mem_wr)
    );

    emu_ram_read_path u_read_path (
        .clk        (clk),
        .breq_valid (breq_valid),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .mem_rd     (mem_rd),
        .rd_data    (rd_data)
    );

    emu_ram_store u_store (
        .clk        (clk),
        .mem_wr     (mem_wr),
        .mem_rd     (mem_rd),
        .rd_data    (rd_data)
    );

endmodule

// File: logic/emu_ram_consts.svh
`ifndef EMU_RAM_CONSTS_SVH
`define EMU_RAM_CONSTS_SVH

// **************************************************
// Bus widths
// **************************************************
`define EMU_ADDR_W          16
`define EMU_DATA_W          64
`define EMU_ID_W            4
`define EMU_LEN_W           8

// Byte lanes per beat, and the address bit where the word index starts
`define EMU_STRB_W          (`EMU_DATA_W / 8)
`define EMU_WORD_LSB        3

// **************************************************
// Memory depth and response timing
// **************************************************
`define EMU_MEM_WORDS_LOG2  10

`define EMU_DLY_W           8
`define EMU_W_DELAY         3
`define EMU_R_DELAY         25

`endif

// File: logic/emu_ram_pkg.sv
`include "emu_ram_consts.svh"

package emu_ram_pkg;

    // **************************************************
    // Plain vector types
    // **************************************************
    typedef logic [`EMU_ADDR_W-1:0]         addr_t;
    typedef logic [`EMU_MEM_WORDS_LOG2-1:0] word_addr_t;
    typedef logic [`EMU_DATA_W-1:0]         data_t;
    typedef logic [`EMU_STRB_W-1:0]         strb_t;
    typedef logic [`EMU_ID_W-1:0]           id_t;
    // Burst length minus one
    typedef logic [`EMU_LEN_W-1:0]          len_t;

    // **************************************************
    // Channel payloads
    // **************************************************

    // Shared by AW and AR
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } addr_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } w_beat_t;

    typedef struct packed {
        id_t   id;
        data_t data;
        logic  last;
    } r_beat_t;

    // Store ports
    typedef struct packed {
        logic       en;
        word_addr_t addr;
        data_t      data;
        strb_t      strb;
    } mem_wr_t;

    typedef struct packed {
        logic       en;
        word_addr_t addr;
    } mem_rd_t;

    // FSM states
    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_WAIT, WR_RESP} wr_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_BURST} rd_state_t;

endpackage

// File: logic/emu_ram_read_path.sv
`timescale 1ns/1ps

`include "emu_ram_consts.svh"

module emu_ram_read_path import emu_ram_pkg::*; (
    input  logic      clk,
    input  logic      breq_valid,

    input  addr_req_t ar,
    input  logic      ar_valid,
    output logic      ar_ready,

    output r_beat_t   r,
    output logic      r_valid,
    input  logic      r_ready,

    output mem_rd_t   mem_rd,
    input  data_t     rd_data
);

    rd_state_t             state;
    rd_state_t             state_next;

    id_t                   id_q;
    len_t                  len_q;
    len_t                  beat_cnt;
    word_addr_t            raddr;
    logic [`EMU_DLY_W-1:0] dly_cnt;

    logic                  ar_fire;
    logic                  r_fire;
    logic                  last_beat;
    logic                  rd_issue;

    assign ar_fire   = ar_valid && ar_ready;
    assign r_valid   = (state == RD_BURST);
    assign r_fire    = r_valid && r_ready;
    assign last_beat = (beat_cnt == len_q);

    // Store output feeds the beat directly
    assign r = '{
        id:   id_q,
        data: rd_data,
        last: last_beat
    };

    // Fetch one cycle ahead; under back-pressure the store holds its output
    assign rd_issue = (state == RD_WAIT && dly_cnt == '0) || (r_fire && !last_beat);

    assign mem_rd = '{
        en:   rd_issue,
        addr: raddr
    };

    // **************************************************
    // Burst FSM
    // **************************************************
    always_comb begin
        state_next = state;
        case (state)
            RD_IDLE: begin
                if (ar_fire) begin
                    state_next = RD_WAIT;
                end
            end
            RD_WAIT: begin
                if (dly_cnt == '0) begin
                    state_next = RD_BURST;
                end
            end
            RD_BURST: begin
                if (r_fire && last_beat) begin
                    state_next = RD_IDLE;
                end
            end
            default: state_next = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge breq_valid) begin
        if (breq_valid) begin
            state    <= RD_IDLE;
            ar_ready <= 1'b0;
            dly_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            state    <= state_next;
            ar_ready <= (state_next == RD_IDLE);
            if (ar_fire) begin
                dly_cnt <= `EMU_DLY_W'(`EMU_R_DELAY);
            end else if (state == RD_WAIT && dly_cnt != '0) begin
                dly_cnt <= dly_cnt - 1'b1;
            end
            if (ar_fire) begin
                beat_cnt <= '0;
            end else if (r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Burst attributes and fetch address
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id_q  <= ar.id;
            len_q <= ar.len;
            raddr <= ar.addr[`EMU_WORD_LSB +: `EMU_MEM_WORDS_LOG2];
        end else if (rd_issue) begin
            raddr <= raddr + 1'b1;
        end
    end

endmodule

// File: logic/emu_ram_store.sv
`timescale 1ns/1ps

`include "emu_ram_consts.svh"

module emu_ram_store import emu_ram_pkg::*; (
    input  logic    clk,

    // From the write path
    input  mem_wr_t mem_wr,

    // From and to the read path
    input  mem_rd_t mem_rd,
    output data_t   rd_data
);

    // **************************************************
    // Shared word array
    // **************************************************
    data_t mem [2**`EMU_MEM_WORDS_LOG2];

    // Byte lane write enables
    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            for (int i = 0; i < `EMU_STRB_W; i++) begin
                if (mem_wr.strb[i]) begin
                    mem[mem_wr.addr][i*8 +: 8] <= mem_wr.data[i*8 +: 8];
                end
            end
        end
    end

    // Registered read port, holds while idle
    // Same-word collision returns the old contents
    always_ff @(posedge clk) begin
        if (mem_rd.en) begin
            rd_data <= mem[mem_rd.addr];
        end
    end

endmodule

// File: logic/emu_ram_write_path.sv
`timescale 1ns/1ps

`include "emu_ram_consts.svh"

module emu_ram_write_path import emu_ram_pkg::*; (
    input  logic      clk,
    input  logic      breq_valid,

    input  addr_req_t aw,
    input  logic      aw_valid,
    output logic      aw_ready,

    input  w_beat_t   w,
    input  logic      w_valid,
    output logic      w_ready,

    output id_t       b_id,
    output logic      b_valid,
    input  logic      b_ready,

    output mem_wr_t   mem_wr
);

    wr_state_t             state;
    wr_state_t             state_next;

    id_t                   id_q;
    word_addr_t            waddr;
    logic [`EMU_DLY_W-1:0] dly_cnt;

    logic                  aw_fire;
    logic                  w_fire;
    logic                  b_fire;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;
    assign b_fire  = b_valid && b_ready;

    assign w_ready = (state == WR_DATA);
    assign b_valid = (state == WR_RESP);
    assign b_id    = id_q;

    // Each accepted beat goes straight into the store
    assign mem_wr = '{
        en:   w_fire,
        addr: waddr,
        data: w.data,
        strb: w.strb
    };

    // **************************************************
    // Burst FSM
    // **************************************************
    always_comb begin
        state_next = state;
        case (state)
            WR_IDLE: begin
                if (aw_fire) begin
                    state_next = WR_DATA;
                end
            end
            WR_DATA: begin
                if (w_fire && w.last) begin
                    state_next = WR_WAIT;
                end
            end
            WR_WAIT: begin
                if (dly_cnt == '0) begin
                    state_next = WR_RESP;
                end
            end
            WR_RESP: begin
                if (b_fire) begin
                    state_next = WR_IDLE;
                end
            end
            default: state_next = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge breq_valid) begin
        if (breq_valid) begin
            state    <= WR_IDLE;
            aw_ready <= 1'b0;
            dly_cnt  <= '0;
        end else begin
            state    <= state_next;
            aw_ready <= (state_next == WR_IDLE);
            // Last beat edge counts as the first of the delay
            if (w_fire && w.last) begin
                dly_cnt <= `EMU_DLY_W'(`EMU_W_DELAY - 1);
            end else if (state == WR_WAIT && dly_cnt != '0) begin
                dly_cnt <= dly_cnt - 1'b1;
            end
        end
    end

    // ID and word address of the current burst
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            id_q  <= aw.id;
            waddr <= aw.addr[`EMU_WORD_LSB +: `EMU_MEM_WORDS_LOG2];
        end else if (w_fire) begin
            waddr <= waddr + 1'b1;
        end
    end

endmodule
